/* build.f */
+incdir+design
design/issue_pkg.sv
design/instruction_fifo.sv
design/thread_scoreboard.sv
design/round_robin_arbiter.sv
design/writeback_slot_tracker.sv
design/thread_select_stage.sv
testbench/thread_select_tb.sv

/* Makefile */
SIM := obj_dir/Vthread_select_tb
SOURCES := $(wildcard design/*.sv design/*.svh testbench/*.sv)

.PHONY: all run clean

all: $(SIM)

$(SIM): build.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module thread_select_tb

run: $(SIM)
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -q "^TEST PASSED$$"

clean:
	rm -rf obj_dir

/* testbench/thread_select_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "issue_macros.svh"

module thread_select_tb;

	localparam int OP_BEGIN = 0;
	localparam int OP_END = 1;
	localparam int OP_ENQ = 2;
	localparam int OP_EXPECT = 3;
	localparam int OP_QUIET = 4;
	localparam int OP_WB = 5;
	localparam int OP_RB = 6;
	localparam int OP_ENABLE = 7;
	localparam int OP_FETCH = 8;

	// Register kinds for destinations and sources in the table
	localparam int K_NONE = 0;
	localparam int K_S = 1;
	localparam int K_V = 2;

	typedef struct packed
	{
		int op;
		int thread;
		int tag;
		int dest_kind;
		int dest_reg;
		int src_kind;
		int src_reg;
		int pipe;
		int last_sub;
		int val;
	} step_t;

	logic clk = 1'b0;
	logic reset = 1'b1;
	issue_pkg::decoded_instruction_t id_instruction;
	logic id_instruction_valid;
	issue_pkg::thread_idx_t id_thread_idx;
	logic [`THREADS_PER_CORE - 1:0] cr_thread_enable;
	logic wb_writeback_en;
	issue_pkg::thread_idx_t wb_writeback_thread_idx;
	logic wb_is_vector;
	issue_pkg::register_idx_t wb_writeback_reg;
	logic wb_rollback_en;
	issue_pkg::thread_idx_t wb_rollback_thread_idx;
	issue_pkg::pipeline_sel_t wb_rollback_pipeline;
	issue_pkg::subcycle_t wb_rollback_subcycle;
	logic wb_rollback_is_last_subcycle;
	logic [`THREADS_PER_CORE - 1:0] ts_fetch_en;
	logic ts_instruction_valid;
	issue_pkg::decoded_instruction_t ts_instruction;
	issue_pkg::thread_idx_t ts_thread_idx;
	issue_pkg::subcycle_t ts_subcycle;

	step_t table_q[$];
	string test_names [6] = '{"round robin", "dependency", "subcycles", "writeback slots",
		"fetch enable", "rollback"};
	issue_pkg::decoded_instruction_t sent_instr [16];

	// Issue records captured by the monitor, consumed in order by expect steps
	issue_pkg::decoded_instruction_t rec_instr[$];
	issue_pkg::thread_idx_t rec_thread[$];
	issue_pkg::subcycle_t rec_sub[$];
	int rec_cycle[$];
	bit landed [int];

	logic [31:0] lfsr_state = 32'h9b3c;
	int cycle = 0;
	int limit = 0;
	int land;
	int errors = 0;
	int test_errors = 0;
	int tests = 0;
	int failed = 0;
	int wb_cycle = 0;
	string cur_name = "reset";

	thread_select_stage u_thread_select_stage (.*);

	always #4 clk = ~clk;

	// Galois LFSR that steps once per bit handed out
	function automatic logic [31:0] lfsr_take(input int nbits);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < nbits; i++)
		begin
			lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	function automatic int pipe_latency(input issue_pkg::pipeline_sel_t p);
		case (p)
			issue_pkg::pipe_mcycle_arith: return `LAT_MCYCLE;
			issue_pkg::pipe_mem: return `LAT_MEM;
			default: return `LAT_SCYCLE;
		endcase
	endfunction

	// Random second operand lives in r16..r31, clear of every destination the tests use
	function automatic issue_pkg::decoded_instruction_t make_instr(input step_t s);
		issue_pkg::decoded_instruction_t d;
		d = '0;
		d.has_dest = s.dest_kind != K_NONE;
		d.dest_is_vector = s.dest_kind == K_V;
		d.dest_reg = 5'(s.dest_reg);
		d.has_scalar1 = s.src_kind == K_S;
		d.has_vector1 = s.src_kind == K_V;
		if (s.src_kind == K_S)
			d.scalar_sel1 = 5'(s.src_reg);
		if (s.src_kind == K_V)
			d.vector_sel1 = 5'(s.src_reg);
		d.has_scalar2 = 1'b1;
		d.scalar_sel2 = 5'd16 + 5'(lfsr_take(4));
		d.pipeline_sel = issue_pkg::pipeline_sel_t'(s.pipe);
		d.last_subcycle = 4'(s.last_sub);
		d.tag = 4'(s.tag);
		return d;
	endfunction

	task automatic report_error(input string msg);
		$display("%s", msg);
		errors++;
		test_errors++;
	endtask

	task automatic check_instruction(input issue_pkg::decoded_instruction_t exp_v,
		input issue_pkg::decoded_instruction_t act_v);
		if (exp_v !== act_v)
			report_error($sformatf("mismatch %s instruction expected %h actual %h",
				cur_name, exp_v, act_v));
	endtask

	task automatic check_thread(input issue_pkg::thread_idx_t exp_v,
		input issue_pkg::thread_idx_t act_v);
		if (exp_v !== act_v)
			report_error($sformatf("mismatch %s thread expected %0d actual %0d",
				cur_name, exp_v, act_v));
	endtask

	task automatic check_subcycle(input issue_pkg::subcycle_t exp_v,
		input issue_pkg::subcycle_t act_v);
		if (exp_v !== act_v)
			report_error($sformatf("mismatch %s subcycle expected %0d actual %0d",
				cur_name, exp_v, act_v));
	endtask

	task automatic check_fetch_en(input logic [`THREADS_PER_CORE - 1:0] exp_v,
		input logic [`THREADS_PER_CORE - 1:0] act_v);
		if (exp_v !== act_v)
			report_error($sformatf("mismatch %s fetch enable expected %b actual %b",
				cur_name, exp_v, act_v));
	endtask

	task automatic add_step(input int op, input int thread, input int tag, input int val);
		step_t s;
		s = '0;
		s.op = op;
		s.thread = thread;
		s.tag = tag;
		s.val = val;
		table_q.push_back(s);
	endtask

	task automatic add_enqueue(input int thread, input int tag, input int dk, input int dr,
		input int sk, input int sr, input int pipe, input int last_sub);
		step_t s;
		s = '{OP_ENQ, thread, tag, dk, dr, sk, sr, pipe, last_sub, 0};
		table_q.push_back(s);
	endtask

	// The src_kind field doubles as the flag to check distance from the last writeback
	task automatic add_expect(input int thread, input int tag, input int sub, input int dep);
		step_t s;
		s = '{OP_EXPECT, thread, tag, 0, 0, dep, 0, 0, 0, sub};
		table_q.push_back(s);
	endtask

	task automatic add_writeback(input int thread, input int kind, input int register);
		step_t s;
		s = '{OP_WB, thread, 0, 0, 0, kind, register, 0, 0, 0};
		table_q.push_back(s);
	endtask

	task automatic add_rollback(input int thread, input int pipe, input int sub, input int last);
		step_t s;
		s = '{OP_RB, thread, 0, 0, 0, 0, 0, pipe, last, sub};
		table_q.push_back(s);
	endtask

	task automatic build_table();
		// All four threads queue two each while disabled, then drain together
		add_step(OP_BEGIN, 0, 0, 0);
		add_step(OP_ENABLE, 0, 0, 4'b0000);
		for (int i = 0; i < 8; i++)
			add_enqueue(i % 4, i + 1, K_NONE, 0, K_NONE, 0, 0, 0);
		add_step(OP_FETCH, 0, 0, 4'b0000);
		add_step(OP_ENABLE, 0, 0, 4'b1111);
		for (int i = 0; i < 8; i++)
			add_expect(i % 4, i + 1, 0, 0);
		add_step(OP_END, 0, 0, 0);
		// Scalar read after write, with a writeback to the wrong thread in between
		add_step(OP_BEGIN, 0, 0, 1);
		add_enqueue(1, 1, K_S, 5, K_NONE, 0, 0, 0);
		add_enqueue(1, 2, K_NONE, 0, K_S, 5, 0, 0);
		add_expect(1, 1, 0, 0);
		add_step(OP_QUIET, 0, 0, 4);
		add_writeback(2, K_S, 5);
		add_step(OP_QUIET, 0, 0, 4);
		add_writeback(1, K_S, 5);
		add_expect(1, 2, 0, 1);
		add_enqueue(1, 3, K_V, 7, K_NONE, 0, 0, 0);
		add_enqueue(1, 4, K_NONE, 0, K_V, 7, 0, 0);
		add_expect(1, 3, 0, 0);
		add_step(OP_QUIET, 0, 0, 4);
		add_writeback(1, K_V, 7);
		add_expect(1, 4, 0, 1);
		add_step(OP_END, 0, 0, 0);
		// Four subcycles out of one instruction
		add_step(OP_BEGIN, 0, 0, 2);
		add_enqueue(2, 1, K_NONE, 0, K_NONE, 0, 0, 3);
		add_enqueue(2, 2, K_NONE, 0, K_NONE, 0, 0, 0);
		for (int i = 0; i < 4; i++)
			add_expect(2, 1, i, 0);
		add_expect(2, 2, 0, 0);
		add_step(OP_END, 0, 0, 0);
		// Mixed latencies on one thread so the fourth one collides with the first
		add_step(OP_BEGIN, 0, 0, 3);
		add_enqueue(3, 1, K_NONE, 0, K_NONE, 0, 1, 0);
		add_enqueue(3, 2, K_NONE, 0, K_NONE, 0, 0, 0);
		add_enqueue(3, 3, K_NONE, 0, K_NONE, 0, 0, 0);
		add_enqueue(3, 4, K_NONE, 0, K_NONE, 0, 0, 0);
		add_enqueue(3, 5, K_NONE, 0, K_NONE, 0, 2, 0);
		add_enqueue(3, 6, K_NONE, 0, K_NONE, 0, 0, 0);
		for (int i = 1; i <= 6; i++)
			add_expect(3, i, 0, 0);
		add_step(OP_END, 0, 0, 0);
		// Three blocked readers fill thread 0 up to the almost full level
		add_step(OP_BEGIN, 0, 0, 4);
		add_enqueue(0, 1, K_S, 9, K_NONE, 0, 0, 0);
		for (int i = 2; i <= 4; i++)
			add_enqueue(0, i, K_NONE, 0, K_S, 9, 0, 0);
		add_expect(0, 1, 0, 0);
		add_step(OP_FETCH, 0, 0, 4'b1110);
		add_step(OP_ENABLE, 0, 0, 4'b1101);
		add_step(OP_FETCH, 0, 0, 4'b1100);
		add_step(OP_ENABLE, 0, 0, 4'b1111);
		add_writeback(0, K_S, 9);
		add_expect(0, 2, 0, 1);
		add_expect(0, 3, 0, 0);
		add_expect(0, 4, 0, 0);
		add_step(OP_FETCH, 0, 0, 4'b1111);
		add_step(OP_END, 0, 0, 0);
		// Rollback while the writer is in flight and a reader waits behind it
		add_step(OP_BEGIN, 0, 0, 5);
		add_enqueue(2, 1, K_S, 12, K_NONE, 0, 0, 0);
		add_enqueue(2, 2, K_NONE, 0, K_S, 12, 0, 0);
		add_enqueue(2, 3, K_NONE, 0, K_NONE, 0, 0, 0);
		add_rollback(2, 0, 2, 1);
		add_expect(2, 1, 0, 0);
		add_step(OP_QUIET, 0, 0, 5);
		add_enqueue(2, 4, K_NONE, 0, K_NONE, 0, 0, 3);
		add_expect(2, 4, 2, 0);
		add_expect(2, 4, 3, 0);
		add_enqueue(2, 5, K_NONE, 0, K_S, 12, 0, 0);
		add_expect(2, 5, 0, 0);
		add_step(OP_END, 0, 0, 0);
	endtask

	// Outputs are registered on the rising edge, so the falling edge sees them settled
	always @(negedge clk)
	begin
		if (!reset && ts_instruction_valid)
		begin
			land = cycle + pipe_latency(ts_instruction.pipeline_sel);
			if (landed.exists(land))
				report_error($sformatf("%s: two instructions write back in cycle %0d",
					cur_name, land));
			landed[land] = 1'b1;
			rec_instr.push_back(ts_instruction);
			rec_thread.push_back(ts_thread_idx);
			rec_sub.push_back(ts_subcycle);
			rec_cycle.push_back(cycle);
		end
	end

	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (limit > 0 && cycle >= limit)
		begin
			$display("timeout: %s still waiting after %0d cycles", cur_name, cycle);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial
	begin
		id_instruction = '0;
		id_instruction_valid = 1'b0;
		id_thread_idx = '0;
		cr_thread_enable = '0;
		wb_writeback_en = 1'b0;
		wb_writeback_thread_idx = '0;
		wb_is_vector = 1'b0;
		wb_writeback_reg = '0;
		wb_rollback_en = 1'b0;
		wb_rollback_thread_idx = '0;
		wb_rollback_pipeline = issue_pkg::pipe_scycle_arith;
		wb_rollback_subcycle = '0;
		wb_rollback_is_last_subcycle = 1'b0;
		build_table();
		limit = table_q.size() * 20;
		repeat (8) @(posedge clk);
		#1 reset = 1'b0;

		foreach (table_q[i])
		begin
			@(posedge clk);
			#1;
			// Strobes last exactly one cycle
			id_instruction_valid = 1'b0;
			wb_writeback_en = 1'b0;
			wb_rollback_en = 1'b0;
			case (table_q[i].op)
				OP_BEGIN:
				begin
					cur_name = test_names[table_q[i].val];
					test_errors = 0;
				end
				OP_ENQ:
				begin
					sent_instr[table_q[i].tag] = make_instr(table_q[i]);
					id_instruction = sent_instr[table_q[i].tag];
					id_thread_idx = 2'(table_q[i].thread);
					id_instruction_valid = 1'b1;
				end
				OP_EXPECT:
				begin
					while (rec_instr.size() == 0)
						@(posedge clk);
					check_thread(2'(table_q[i].thread), rec_thread.pop_front());
					check_subcycle(4'(table_q[i].val), rec_sub.pop_front());
					check_instruction(sent_instr[table_q[i].tag], rec_instr.pop_front());
					if (table_q[i].src_kind != 0 && rec_cycle[0] - wb_cycle < 2)
						report_error($sformatf(
							"%s: dependent instruction issued %0d cycles after its writeback",
							cur_name, rec_cycle[0] - wb_cycle));
					void'(rec_cycle.pop_front());
				end
				OP_QUIET, OP_END:
				begin
					repeat (table_q[i].op == OP_END ? 4 : table_q[i].val) @(posedge clk);
					if (rec_instr.size() != 0)
						report_error($sformatf("%s: tag %0d issued although it should be held",
							cur_name, rec_instr[0].tag));
					rec_instr.delete();
					rec_thread.delete();
					rec_sub.delete();
					rec_cycle.delete();
					if (table_q[i].op == OP_END)
					begin
						$display("test %s: %s, %0d errors", cur_name,
							test_errors == 0 ? "ok" : "failed", test_errors);
						tests++;
						if (test_errors != 0)
							failed++;
					end
				end
				OP_WB:
				begin
					wb_writeback_thread_idx = 2'(table_q[i].thread);
					wb_is_vector = table_q[i].src_kind == K_V;
					wb_writeback_reg = 5'(table_q[i].src_reg);
					wb_writeback_en = 1'b1;
					wb_cycle = cycle;
				end
				OP_RB:
				begin
					wb_rollback_thread_idx = 2'(table_q[i].thread);
					wb_rollback_pipeline = issue_pkg::pipeline_sel_t'(table_q[i].pipe);
					wb_rollback_subcycle = 4'(table_q[i].val);
					wb_rollback_is_last_subcycle = table_q[i].last_sub != 0;
					wb_rollback_en = 1'b1;
				end
				OP_ENABLE:
					cr_thread_enable = 4'(table_q[i].val);
				OP_FETCH:
				begin
					// The enable is registered, so give it a few cycles to follow the FIFOs
					repeat (3) @(posedge clk);
					#1;
					check_fetch_en(4'(table_q[i].val), ts_fetch_en);
				end
				default:
					report_error($sformatf("%s: unknown table step %0d", cur_name, i));
			endcase
		end

		$display("tests run %0d, tests failed %0d, errors %0d", tests, failed, errors);
		if (errors == 0 && failed == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* design/thread_select_stage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "issue_macros.svh"

module thread_select_stage
(
	input wire logic clk,
	input wire logic reset,

	// Decode
	input wire issue_pkg::decoded_instruction_t id_instruction,
	input wire logic id_instruction_valid,
	input wire issue_pkg::thread_idx_t id_thread_idx,

	// Thread enables from the control registers
	input wire logic [`THREADS_PER_CORE - 1:0] cr_thread_enable,

	// Writeback and rollback
	input wire logic wb_writeback_en,
	input wire issue_pkg::thread_idx_t wb_writeback_thread_idx,
	input wire logic wb_is_vector,
	input wire issue_pkg::register_idx_t wb_writeback_reg,
	input wire logic wb_rollback_en,
	input wire issue_pkg::thread_idx_t wb_rollback_thread_idx,
	input wire issue_pkg::pipeline_sel_t wb_rollback_pipeline,
	input wire issue_pkg::subcycle_t wb_rollback_subcycle,
	input wire logic wb_rollback_is_last_subcycle,

	// Fetch and operand fetch
	output logic [`THREADS_PER_CORE - 1:0] ts_fetch_en,
	output logic ts_instruction_valid,
	output issue_pkg::decoded_instruction_t ts_instruction,
	output issue_pkg::thread_idx_t ts_thread_idx,
	output issue_pkg::subcycle_t ts_subcycle
);

	localparam int THREADS = `THREADS_PER_CORE;
	localparam int STAGES = `ROLLBACK_STAGES;

	issue_pkg::decoded_instruction_t head [THREADS];
	issue_pkg::scoreboard_bits_t dest_bits [THREADS];
	issue_pkg::scoreboard_bits_t rollback_clear [THREADS];
	issue_pkg::subcycle_t current_subcycle [THREADS];
	logic [THREADS - 1:0] fifo_empty;
	logic [THREADS - 1:0] fifo_almost_full;
	logic [THREADS - 1:0] deps_clear;
	logic [THREADS - 1:0] slot_free;
	logic [THREADS - 1:0] can_issue;
	logic [THREADS - 1:0] grant;
	logic [THREADS - 1:0] instruction_complete;
	logic slot_free_scycle;
	logic slot_free_mcycle;
	logic slot_free_mem;
	logic issue_en;
	issue_pkg::thread_idx_t issue_thread_idx;
	issue_pkg::decoded_instruction_t issue_instr;

	// Completed instructions with a destination, kept until they can no longer be rolled back
	logic hist_valid [STAGES];
	issue_pkg::thread_idx_t hist_thread [STAGES];
	issue_pkg::scoreboard_bits_t hist_bits [STAGES];

	for (genvar t = 0; t < THREADS; t++)
	begin : thread_gen
		logic rollback_this;

		assign rollback_this = wb_rollback_en
			&& wb_rollback_thread_idx == issue_pkg::thread_idx_t'(t);

		instruction_fifo #(
			.DEPTH(`IFIFO_DEPTH),
			.ALMOST_FULL(`IFIFO_ALMOST_FULL)
		) ififo (
			.clk(clk),
			.reset(reset),
			.flush(rollback_this),
			.enqueue(id_instruction_valid && id_thread_idx == issue_pkg::thread_idx_t'(t)),
			.data_in(id_instruction),
			.dequeue(instruction_complete[t]),
			.data_out(head[t]),
			.empty(fifo_empty[t]),
			.almost_full(fifo_almost_full[t])
		);

		// Instruction leaves the FIFO when its last subcycle is issued
		assign instruction_complete[t] = grant[t]
			&& current_subcycle[t] == head[t].last_subcycle;

		// Undo destinations of this thread's instructions still in flight
		// A memory fault comes one stage later, so only it reaches the oldest entry
		always_comb
		begin
			rollback_clear[t].flat = '0;
			if (rollback_this && wb_rollback_is_last_subcycle)
			begin
				for (int s = 0; s < STAGES; s++)
				begin
					if (hist_valid[s] && hist_thread[s] == issue_pkg::thread_idx_t'(t)
						&& (s < STAGES - 1 || wb_rollback_pipeline == issue_pkg::pipe_mem))
						rollback_clear[t].flat = rollback_clear[t].flat | hist_bits[s].flat;
				end
			end
		end

		thread_scoreboard sb (
			.clk(clk),
			.reset(reset),
			.head(head[t]),
			.issued(instruction_complete[t]),
			.writeback_en(wb_writeback_en
				&& wb_writeback_thread_idx == issue_pkg::thread_idx_t'(t)),
			.writeback_vector(wb_is_vector),
			.writeback_reg(wb_writeback_reg),
			.rollback_clear(rollback_clear[t]),
			.first_subcycle(current_subcycle[t] == '0),
			.deps_clear(deps_clear[t]),
			.dest_bits(dest_bits[t])
		);

		always_comb
		begin
			case (head[t].pipeline_sel)
				issue_pkg::pipe_mcycle_arith: slot_free[t] = slot_free_mcycle;
				issue_pkg::pipe_mem: slot_free[t] = slot_free_mem;
				default: slot_free[t] = slot_free_scycle;
			endcase
		end

		assign can_issue[t] = !fifo_empty[t] && deps_clear[t] && cr_thread_enable[t]
			&& !rollback_this && slot_free[t];
	end

	round_robin_arbiter #(.NUM_REQUESTS(THREADS)) arbiter (
		.clk(clk),
		.reset(reset),
		.request(can_issue),
		.grant(grant)
	);

	always_comb
	begin
		issue_thread_idx = '0;
		for (int i = 0; i < THREADS; i++)
		begin
			if (grant[i])
				issue_thread_idx = issue_pkg::thread_idx_t'(i);
		end
	end

	assign issue_en = |grant;
	assign issue_instr = head[issue_thread_idx];

	writeback_slot_tracker slots (
		.clk(clk),
		.reset(reset),
		.issue_en(issue_en),
		.issue_pipeline(issue_instr.pipeline_sel),
		.slot_free_scycle(slot_free_scycle),
		.slot_free_mcycle(slot_free_mcycle),
		.slot_free_mem(slot_free_mem)
	);

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			ts_instruction_valid <= 1'b0;
			ts_fetch_en <= '0;
			for (int i = 0; i < THREADS; i++)
				current_subcycle[i] <= '0;

			for (int s = 0; s < STAGES; s++)
				hist_valid[s] <= 1'b0;
		end
		else
		begin
			ts_instruction_valid <= issue_en;

			// Fetch backs off early since several stages sit between fetch and this FIFO
			ts_fetch_en <= ~fifo_almost_full & cr_thread_enable;

			// Rollback restarts the thread at the subcycle that faulted
			for (int i = 0; i < THREADS; i++)
			begin
				if (wb_rollback_en && wb_rollback_thread_idx == issue_pkg::thread_idx_t'(i))
					current_subcycle[i] <= wb_rollback_subcycle;
				else if (instruction_complete[i])
					current_subcycle[i] <= '0;
				else if (grant[i])
					current_subcycle[i] <= current_subcycle[i] + 4'd1;
			end

			// Entries of a rolled back thread are dropped as they shift
			for (int s = 1; s < STAGES; s++)
				hist_valid[s] <= hist_valid[s - 1]
					&& !(wb_rollback_en && hist_thread[s - 1] == wb_rollback_thread_idx);

			hist_valid[0] <= issue_en && instruction_complete[issue_thread_idx]
				&& issue_instr.has_dest;
		end
	end

	always_ff @(posedge clk)
	begin
		ts_instruction <= issue_instr;
		ts_thread_idx <= issue_thread_idx;
		ts_subcycle <= current_subcycle[issue_thread_idx];
		for (int s = 1; s < STAGES; s++)
		begin
			hist_thread[s] <= hist_thread[s - 1];
			hist_bits[s] <= hist_bits[s - 1];
		end

		hist_thread[0] <= issue_thread_idx;
		hist_bits[0] <= dest_bits[issue_thread_idx];
	end

endmodule

`default_nettype wire

/* design/writeback_slot_tracker.sv */
`timescale 1ns/10ps
`default_nettype none

`include "issue_macros.svh"

module writeback_slot_tracker
(
	input wire logic clk,
	input wire logic reset,
	input wire logic issue_en,
	input wire issue_pkg::pipeline_sel_t issue_pipeline,
	output logic slot_free_scycle,
	output logic slot_free_mcycle,
	output logic slot_free_mem
);

	localparam int SLOTS = `WB_SLOTS;

	// Bit k set means the writeback port is taken k cycles from now
	logic [SLOTS - 1:0] reserved;
	logic [SLOTS - 1:0] issue_mask;
	int issue_latency;

	always_comb
	begin
		case (issue_pipeline)
			issue_pkg::pipe_mcycle_arith: issue_latency = `LAT_MCYCLE;
			issue_pkg::pipe_mem: issue_latency = `LAT_MEM;
			default: issue_latency = `LAT_SCYCLE;
		endcase
	end

	// An instruction may go out only if its own landing cycle is still open
	assign slot_free_scycle = !reserved[`LAT_SCYCLE];
	assign slot_free_mcycle = !reserved[`LAT_MCYCLE];
	assign slot_free_mem = !reserved[`LAT_MEM];

	// Every instruction claims its slot, even one with no destination register
	assign issue_mask = issue_en ? {{(SLOTS - 1){1'b0}}, 1'b1} << issue_latency : '0;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			reserved <= '0;
		else
			reserved <= (reserved | issue_mask) >> 1;
	end

	// The top block must combine these flags with the pipeline of the thread it grants
	slot_not_taken: assert property (@(posedge clk) disable iff (reset)
		issue_en |-> !reserved[issue_latency]);

endmodule

`default_nettype wire

/* design/round_robin_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

`include "issue_macros.svh"

module round_robin_arbiter
#(
	parameter int NUM_REQUESTS = `THREADS_PER_CORE
)
(
	input wire logic clk,
	input wire logic reset,
	input wire logic [NUM_REQUESTS - 1:0] request,
	output logic [NUM_REQUESTS - 1:0] grant
);

	localparam int IDX_W = (NUM_REQUESTS > 1) ? $clog2(NUM_REQUESTS) : 1;

	logic [IDX_W - 1:0] last_winner;
	logic [IDX_W - 1:0] winner;

	// Search starts just past the last winner and wraps around
	// The last winner itself is checked last, so it only wins again when alone
	always_comb
	begin
		int idx;
		logic found;

		grant = '0;
		winner = last_winner;
		found = 1'b0;
		for (int i = 1; i <= NUM_REQUESTS; i++)
		begin
			idx = (int'(last_winner) + i) % NUM_REQUESTS;
			if (!found && request[idx])
			begin
				grant[idx] = 1'b1;
				winner = IDX_W'(idx);
				found = 1'b1;
			end
		end
	end

	// Priority only moves when somebody was granted
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			last_winner <= IDX_W'(NUM_REQUESTS - 1);
		else if (|request)
			last_winner <= winner;
	end

	// Last cycle's winner loses to any other requester in this cycle
	winner_yields: assert property (@(posedge clk) disable iff (reset)
		(request & ~$past(grant)) != '0 |-> (grant & $past(grant)) == '0);

endmodule

`default_nettype wire

/* design/thread_scoreboard.sv */
`timescale 1ns/10ps
`default_nettype none

module thread_scoreboard
(
	input wire logic clk,
	input wire logic reset,
	input wire issue_pkg::decoded_instruction_t head,
	input wire logic issued,
	input wire logic writeback_en,
	input wire logic writeback_vector,
	input wire issue_pkg::register_idx_t writeback_reg,
	input wire issue_pkg::scoreboard_bits_t rollback_clear,
	input wire logic first_subcycle,
	output logic deps_clear,
	output issue_pkg::scoreboard_bits_t dest_bits
);

	issue_pkg::scoreboard_bits_t busy;
	issue_pkg::scoreboard_bits_t dep_bits;
	issue_pkg::scoreboard_bits_t clear_bits;

	function automatic logic [31:0] reg_one_hot(input issue_pkg::register_idx_t idx);
		reg_one_hot = 32'd1 << idx;
	endfunction

	// Destination mask of the instruction at the FIFO head
	always_comb
	begin
		dest_bits.flat = '0;
		if (head.has_dest)
		begin
			if (head.dest_is_vector)
				dest_bits.half.vector = reg_one_hot(head.dest_reg);
			else
				dest_bits.half.scalar = reg_one_hot(head.dest_reg);
		end
	end

	// Registers the head depends on
	// Sources catch read after write, and the destination catches write after write
	always_comb
	begin
		dep_bits = dest_bits;
		if (head.has_scalar1)
			dep_bits.half.scalar = dep_bits.half.scalar | reg_one_hot(head.scalar_sel1);

		if (head.has_scalar2)
			dep_bits.half.scalar = dep_bits.half.scalar | reg_one_hot(head.scalar_sel2);

		if (head.has_vector1)
			dep_bits.half.vector = dep_bits.half.vector | reg_one_hot(head.vector_sel1);

		if (head.has_vector2)
			dep_bits.half.vector = dep_bits.half.vector | reg_one_hot(head.vector_sel2);
	end

	// Only the first subcycle waits on the scoreboard
	// Later subcycles of the same instruction go out back to back
	assign deps_clear = !first_subcycle || (busy.flat & dep_bits.flat) == '0;

	// Bits freed this cycle by writeback and by rollback of in-flight instructions
	always_comb
	begin
		clear_bits = rollback_clear;
		if (writeback_en)
		begin
			if (writeback_vector)
				clear_bits.half.vector = clear_bits.half.vector | reg_one_hot(writeback_reg);
			else
				clear_bits.half.scalar = clear_bits.half.scalar | reg_one_hot(writeback_reg);
		end
	end

	// Issued is raised by the top block on the last subcycle only
	// The destination turns busy once the whole instruction has gone out
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			busy.flat <= '0;
		else
			busy.flat <= (busy.flat & ~clear_bits.flat) | (issued ? dest_bits.flat : 64'd0);
	end

endmodule

`default_nettype wire

/* design/instruction_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

`include "issue_macros.svh"

module instruction_fifo
#(
	parameter int DEPTH = `IFIFO_DEPTH,
	parameter int ALMOST_FULL = `IFIFO_ALMOST_FULL
)
(
	input wire logic clk,
	input wire logic reset,
	input wire logic flush,
	input wire logic enqueue,
	input wire issue_pkg::decoded_instruction_t data_in,
	input wire logic dequeue,
	output issue_pkg::decoded_instruction_t data_out,
	output logic empty,
	output logic almost_full
);

	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	issue_pkg::decoded_instruction_t storage [DEPTH];
	logic [PTR_W - 1:0] rd_ptr;
	logic [PTR_W - 1:0] wr_ptr;
	logic [CNT_W - 1:0] count;
	logic full;
	logic do_enqueue;
	logic do_dequeue;

	// A flush wins over anything else in the same cycle, so the FIFO is empty afterwards
	assign do_enqueue = enqueue && !flush;
	assign do_dequeue = dequeue && !flush;

	assign empty = count == '0;
	assign full = count == CNT_W'(DEPTH);
	assign almost_full = count >= CNT_W'(ALMOST_FULL);

	// The head is read straight out of storage, so a new entry shows up one edge after enqueue
	assign data_out = storage[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (do_enqueue)
			storage[wr_ptr] <= data_in;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end
		else if (flush)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end
		else
		begin
			// Depth need not be a power of two, so the pointers wrap by compare
			if (do_enqueue)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;

			if (do_dequeue)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

			if (do_enqueue && !do_dequeue)
				count <= count + 1'b1;
			else if (do_dequeue && !do_enqueue)
				count <= count - 1'b1;
		end
	end

	// Decode is expected to stop once fetch enable drops, well before the FIFO fills
	enqueue_not_full: assert property (@(posedge clk) disable iff (reset)
		!(enqueue && full));

	// Issue only dequeues a thread whose FIFO holds an instruction
	dequeue_not_empty: assert property (@(posedge clk) disable iff (reset)
		!(dequeue && empty));

endmodule

`default_nettype wire

/* design/issue_pkg.sv */
`default_nettype none

`include "issue_macros.svh"

package issue_pkg;

	typedef logic [$clog2(`THREADS_PER_CORE) - 1:0] thread_idx_t;
	typedef logic [4:0] register_idx_t;
	typedef logic [3:0] subcycle_t;

	// Pipeline that executes an instruction, which sets its writeback latency
	typedef enum logic [1:0]
	{
		pipe_scycle_arith,
		pipe_mcycle_arith,
		pipe_mem
	} pipeline_sel_t;

	// Instruction as delivered by decode
	// The tag only identifies the instruction and has no effect on issue
	typedef struct packed
	{
		logic has_dest;
		logic dest_is_vector;
		register_idx_t dest_reg;
		logic has_scalar1;
		register_idx_t scalar_sel1;
		logic has_scalar2;
		register_idx_t scalar_sel2;
		logic has_vector1;
		register_idx_t vector_sel1;
		logic has_vector2;
		register_idx_t vector_sel2;
		pipeline_sel_t pipeline_sel;
		subcycle_t last_subcycle;
		logic [3:0] tag;
	} decoded_instruction_t;

	// One bit per register of a thread
	// Vector registers sit in the upper half and scalar registers in the lower half
	typedef union packed
	{
		logic [63:0] flat;
		struct packed
		{
			logic [31:0] vector;
			logic [31:0] scalar;
		} half;
	} scoreboard_bits_t;

endpackage

`default_nettype wire

/* design/issue_macros.svh */
`ifndef ISSUE_MACROS_SVH
`define ISSUE_MACROS_SVH

// Number of hardware threads sharing the issue stage
`define THREADS_PER_CORE 4

// Entries in each thread's instruction FIFO
`define IFIFO_DEPTH 5

// Fill level at which fetch for a thread is held off
`define IFIFO_ALMOST_FULL 3

// Cycles from issue to writeback for each pipeline
`define LAT_SCYCLE 1
`define LAT_MCYCLE 4
`define LAT_MEM 3

// Length of the writeback reservation shift register
`define WB_SLOTS 5

// Depth of the in-flight history used to undo scoreboard bits on rollback
`define ROLLBACK_STAGES 4

`endif
